// ==== design/spi_pkg.sv ====
// spi master constants: register map, field widths, reset values and fsm states
package spi_pkg;

	localparam int adr_w  = 14;
	localparam int data_w = 32;

	localparam int div_w  = 10;
	localparam int coml_w = 3;
	localparam int datl_w = 5;
	localparam int buf_aw = 2;

	// io bus word addresses
	localparam logic [adr_w-1:0] adr_exec = 14'h3C80;
	localparam logic [adr_w-1:0] adr_mode = 14'h3C81;
	localparam logic [adr_w-1:0] adr_sdiv = 14'h3C82;
	localparam logic [adr_w-1:0] adr_coml = 14'h3C83;
	localparam logic [adr_w-1:0] adr_comv = 14'h3C84;
	localparam logic [adr_w-1:0] adr_datl = 14'h3C85;
	// buffer words 3C88..3C8B
	localparam logic [adr_w-buf_aw-1:0] adr_datx = 12'hF22;

	localparam int exec_run   = 0;
	localparam int exec_write = 1;
	localparam int exec_cs1   = 3;

	localparam int mode_select_io = 0;
	localparam int mode_cpha      = 1;
	localparam int mode_cpol      = 2;
	localparam int mode_cmd_msb   = 3;
	localparam int mode_dat_msb   = 5;

	// implemented mode bits, the rest read as zero
	localparam logic [data_w-1:0] mode_mask = (data_w'(1) << mode_select_io) |
		(data_w'(1) << mode_cpha) | (data_w'(1) << mode_cpol) |
		(data_w'(1) << mode_cmd_msb) | (data_w'(1) << mode_dat_msb);
	localparam logic [data_w-1:0] mode_reset = data_w'(1) << mode_select_io;
	localparam logic [coml_w-1:0] coml_reset = 3'd1;

	localparam logic [2:0] st_idle  = 3'b000;
	localparam logic [2:0] st_wtcmd = 3'b001;
	localparam logic [2:0] st_wtdat = 3'b010;
	localparam logic [2:0] st_prewt = 3'b011;
	localparam logic [2:0] st_rdcmd = 3'b101;
	localparam logic [2:0] st_rddat = 3'b110;
	localparam logic [2:0] st_wait  = 3'b111;

endpackage

// ==== design/spi_regs.sv ====
`timescale 1ns/10ps
// spi register block: io bus decode, control registers and read-back select
module spi_regs (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          dma_io_we,
	input  logic [spi_pkg::adr_w-1:0]     dma_io_wadr,
	input  logic [spi_pkg::data_w-1:0]    dma_io_wdata,
	input  logic [spi_pkg::adr_w-1:0]     dma_io_radr,
	input  logic                          dma_io_radr_en,
	input  logic [spi_pkg::data_w-1:0]    dma_io_rdata_in,
	input  logic [spi_pkg::data_w-1:0]    buf_rdata,
	input  logic                          run_done,
	output logic [spi_pkg::data_w-1:0]    dma_io_rdata,
	output logic                          bus_we_buf,
	output logic                          bus_rd_buf,
	output logic [spi_pkg::buf_aw-1:0]    bus_buf_adr,
	output logic                          run,
	output logic                          write_mode,
	output logic                          cs1,
	output logic                          select_io,
	output logic                          cpol,
	output logic                          cpha,
	output logic                          cmd_msb,
	output logic                          dat_msb,
	output logic [spi_pkg::div_w-1:0]     sck_div,
	output logic [spi_pkg::coml_w-1:0]    cmd_len,
	output logic [spi_pkg::data_w-1:0]    cmd_val,
	output logic [spi_pkg::datl_w-1:0]    dat_len
);

	logic we_exec, we_mode, we_sdiv, we_coml, we_comv, we_datl, we_datx;
	logic [6:0] rd_sel;
	logic [6:0] rd_q;
	logic [spi_pkg::buf_aw-1:0] rd_adr_q;
	logic [spi_pkg::data_w-1:0] mode_q;

	assign we_exec = dma_io_we && dma_io_wadr == spi_pkg::adr_exec;
	assign we_mode = dma_io_we && dma_io_wadr == spi_pkg::adr_mode;
	assign we_sdiv = dma_io_we && dma_io_wadr == spi_pkg::adr_sdiv;
	assign we_coml = dma_io_we && dma_io_wadr == spi_pkg::adr_coml;
	assign we_comv = dma_io_we && dma_io_wadr == spi_pkg::adr_comv;
	assign we_datl = dma_io_we && dma_io_wadr == spi_pkg::adr_datl;
	assign we_datx = dma_io_we &&
		dma_io_wadr[spi_pkg::adr_w-1:spi_pkg::buf_aw] == spi_pkg::adr_datx;

	// order: exec mode sdiv coml comv datl datx
	assign rd_sel[0] = dma_io_radr_en && dma_io_radr == spi_pkg::adr_exec;
	assign rd_sel[1] = dma_io_radr_en && dma_io_radr == spi_pkg::adr_mode;
	assign rd_sel[2] = dma_io_radr_en && dma_io_radr == spi_pkg::adr_sdiv;
	assign rd_sel[3] = dma_io_radr_en && dma_io_radr == spi_pkg::adr_coml;
	assign rd_sel[4] = dma_io_radr_en && dma_io_radr == spi_pkg::adr_comv;
	assign rd_sel[5] = dma_io_radr_en && dma_io_radr == spi_pkg::adr_datl;
	assign rd_sel[6] = dma_io_radr_en &&
		dma_io_radr[spi_pkg::adr_w-1:spi_pkg::buf_aw] == spi_pkg::adr_datx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run        <= 1'b0;
			write_mode <= 1'b0;
			cs1        <= 1'b0;
			mode_q     <= spi_pkg::mode_reset;
			sck_div    <= '0;
			cmd_len    <= spi_pkg::coml_reset;
			cmd_val    <= '0;
			dat_len    <= '0;
			rd_q       <= '0;
			rd_adr_q   <= '0;
		end else begin
			// end of transaction wins over a bus write
			if (run_done)
				run <= 1'b0;
			else if (we_exec)
				run <= dma_io_wdata[spi_pkg::exec_run];
			if (we_exec) begin
				write_mode <= dma_io_wdata[spi_pkg::exec_write];
				cs1        <= dma_io_wdata[spi_pkg::exec_cs1];
			end
			if (we_mode)
				mode_q <= dma_io_wdata & spi_pkg::mode_mask;
			if (we_sdiv)
				sck_div <= dma_io_wdata[spi_pkg::div_w-1:0];
			if (we_coml)
				cmd_len <= dma_io_wdata[spi_pkg::coml_w-1:0];
			if (we_comv)
				cmd_val <= dma_io_wdata;
			if (we_datl)
				dat_len <= dma_io_wdata[spi_pkg::datl_w-1:0];
			rd_q <= rd_sel;
			if (dma_io_radr_en)
				rd_adr_q <= dma_io_radr[spi_pkg::buf_aw-1:0];
		end
	end

	assign select_io = mode_q[spi_pkg::mode_select_io];
	assign cpha      = mode_q[spi_pkg::mode_cpha];
	assign cpol      = mode_q[spi_pkg::mode_cpol];
	assign cmd_msb   = mode_q[spi_pkg::mode_cmd_msb];
	assign dat_msb   = mode_q[spi_pkg::mode_dat_msb];

	// buffer port: a write uses the current address, a read the latched one
	assign bus_we_buf  = we_datx;
	assign bus_rd_buf  = rd_q[6];
	assign bus_buf_adr = we_datx ? dma_io_wadr[spi_pkg::buf_aw-1:0] : rd_adr_q;

	always_comb begin
		dma_io_rdata = '0;
		if (rd_q[0]) begin
			dma_io_rdata[spi_pkg::exec_run]   = run;
			dma_io_rdata[spi_pkg::exec_write] = write_mode;
			dma_io_rdata[spi_pkg::exec_cs1]   = cs1;
		end else if (rd_q[1])
			dma_io_rdata = mode_q;
		else if (rd_q[2])
			dma_io_rdata[spi_pkg::div_w-1:0] = sck_div;
		else if (rd_q[3])
			dma_io_rdata[spi_pkg::coml_w-1:0] = cmd_len;
		else if (rd_q[4])
			dma_io_rdata = cmd_val;
		else if (rd_q[5])
			dma_io_rdata[spi_pkg::datl_w-1:0] = dat_len;
		else if (rd_q[6])
			dma_io_rdata = buf_rdata;
		else
			// other devices on the bus
			dma_io_rdata = dma_io_rdata_in;
	end

endmodule

// ==== design/spi_buffer.sv ====
`timescale 1ns/10ps
// spi data buffer: four words shared by the io bus and the transfer engine
module spi_buffer (
	input  logic                          clk,
	input  logic                          bus_we,
	input  logic [spi_pkg::buf_aw-1:0]    bus_adr,
	input  logic [spi_pkg::data_w-1:0]    bus_wdata,
	input  logic                          bus_rd,
	input  logic [spi_pkg::buf_aw-1:0]    eng_adr,
	input  logic                          rx_we,
	input  logic [spi_pkg::buf_aw-1:0]    rx_adr,
	input  logic [spi_pkg::data_w-1:0]    rx_data,
	output logic [spi_pkg::data_w-1:0]    rdata
);

	logic [spi_pkg::data_w-1:0] mem [2**spi_pkg::buf_aw];
	logic [spi_pkg::buf_aw-1:0] radr;

	// bus write beats a receive write
	always_ff @(posedge clk) begin
		if (bus_we)
			mem[bus_adr] <= bus_wdata;
		else if (rx_we)
			mem[rx_adr] <= rx_data;
	end

	// pending bus read beats the engine
	assign radr  = bus_rd ? bus_adr : eng_adr;
	assign rdata = mem[radr];

endmodule

// ==== design/spi_clock_gen.sv ====
`timescale 1ns/10ps
// spi clock generator: divided internal clock with shift and sample strobes
module spi_clock_gen (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [spi_pkg::div_w-1:0]     sck_div,
	input  logic                          cpha,
	output logic                          int_sck,
	output logic                          shift_edge,
	output logic                          sample_edge
);

	logic [spi_pkg::div_w-1:0] div_cnt;
	logic sck_t;
	logic sck_d;
	logic rise;
	logic fall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			sck_t   <= 1'b0;
			sck_d   <= 1'b0;
		end else begin
			sck_d <= sck_t;
			// >= so a smaller divide takes effect at once
			if (div_cnt >= sck_div) begin
				div_cnt <= '0;
				sck_t   <= ~sck_t;
			end else begin
				div_cnt <= div_cnt + 10'd1;
			end
		end
	end

	// strobes lead the delayed clock by one cycle,
	// so logic on a strobe changes together with the edge
	assign rise = sck_t && !sck_d;
	assign fall = !sck_t && sck_d;

	assign int_sck     = sck_d;
	assign shift_edge  = cpha ? rise : fall;
	assign sample_edge = cpha ? fall : rise;

endmodule

// ==== design/spi_sequencer.sv ====
`timescale 1ns/10ps
// spi transfer fsm: command and data phases, counters and mosi bit select
module spi_sequencer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          write_mode,
	input  logic                          cpol,
	input  logic                          cpha,
	input  logic                          cmd_msb,
	input  logic                          dat_msb,
	input  logic [spi_pkg::coml_w-1:0]    cmd_len,
	input  logic [spi_pkg::data_w-1:0]    cmd_val,
	input  logic [spi_pkg::datl_w-1:0]    dat_len,
	input  logic [spi_pkg::data_w-1:0]    buf_rdata,
	input  logic                          shift_edge,
	input  logic                          rx_end,
	output logic                          mosi,
	output logic [spi_pkg::buf_aw-1:0]    word_sel,
	output logic                          sck_en,
	output logic                          cs_active,
	output logic                          rx_active,
	output logic                          run_done
);

	logic [2:0] state;
	logic [2:0] state_nx;
	logic [2:0] bit_cnt;
	logic [2:0] bit_nx;
	logic [1:0] byte_cnt;
	logic [1:0] byte_nx;
	logic [spi_pkg::buf_aw-1:0] word_cnt;
	logic [spi_pkg::buf_aw-1:0] word_nx;
	logic [2:0] cmd_bi;
	logic [2:0] dat_bi;
	logic [spi_pkg::coml_w-1:0] cmd_m1;
	logic [spi_pkg::datl_w-1:0] dat_m1;
	logic cmd_last;
	logic dat_last;
	logic mosi_nx;

	// a length of zero wraps to the maximum
	assign cmd_m1   = cmd_len - 3'd1;
	assign dat_m1   = dat_len - 5'd1;
	assign cmd_last = bit_cnt == 3'd7 && byte_cnt == cmd_m1[1:0];
	assign dat_last = bit_cnt == 3'd7 && {word_cnt, byte_cnt} == dat_m1[3:0];

	always_comb begin
		state_nx = state;
		{word_nx, byte_nx, bit_nx} = {word_cnt, byte_cnt, bit_cnt} + 7'd1;
		case (state)
			spi_pkg::st_idle:
				if (run) begin
					if (cpha && cpol)
						state_nx = spi_pkg::st_prewt;
					else
						state_nx = write_mode ? spi_pkg::st_wtcmd : spi_pkg::st_rdcmd;
				end
			// one sck period of chip select before the first edge
			spi_pkg::st_prewt:
				state_nx = write_mode ? spi_pkg::st_wtcmd : spi_pkg::st_rdcmd;
			spi_pkg::st_wtcmd:
				if (cmd_last)
					state_nx = spi_pkg::st_wtdat;
			spi_pkg::st_rdcmd:
				if (cmd_last)
					state_nx = spi_pkg::st_rddat;
			spi_pkg::st_wtdat:
				if (dat_last)
					state_nx = spi_pkg::st_wait;
			spi_pkg::st_rddat:
				if (rx_end)
					state_nx = spi_pkg::st_wait;
			default:
				state_nx = spi_pkg::st_idle;
		endcase
		// every phase starts at bit 0 of byte 0
		if (state_nx != state || state_nx == spi_pkg::st_idle)
			{word_nx, byte_nx, bit_nx} = '0;
		cmd_bi = cmd_msb ? ~bit_nx : bit_nx;
		dat_bi = dat_msb ? ~bit_nx : bit_nx;
		case (state_nx)
			spi_pkg::st_wtcmd, spi_pkg::st_rdcmd:
				mosi_nx = cmd_val[{byte_nx, cmd_bi}];
			spi_pkg::st_wtdat:
				mosi_nx = buf_rdata[{byte_nx, dat_bi}];
			default:
				mosi_nx = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= spi_pkg::st_idle;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			word_cnt <= '0;
			mosi     <= 1'b0;
		end else if (shift_edge) begin
			state    <= state_nx;
			bit_cnt  <= bit_nx;
			byte_cnt <= byte_nx;
			word_cnt <= word_nx;
			mosi     <= mosi_nx;
		end
	end

	// buffer is read at the word of the next bit
	assign word_sel  = word_nx;
	assign sck_en    = state inside {spi_pkg::st_wtcmd, spi_pkg::st_wtdat,
		spi_pkg::st_rdcmd, spi_pkg::st_rddat};
	assign cs_active = state != spi_pkg::st_idle;
	assign rx_active = state == spi_pkg::st_rddat;
	assign run_done  = shift_edge && state == spi_pkg::st_wait;

endmodule

// ==== design/spi_miso_rx.sv ====
`timescale 1ns/10ps
// spi receiver: samples miso into bytes and writes whole words to the buffer
module spi_miso_rx (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          miso,
	input  logic                          sample_edge,
	input  logic                          rx_active,
	input  logic [spi_pkg::datl_w-1:0]    dat_len,
	input  logic                          dat_msb,
	output logic                          rx_we,
	output logic [spi_pkg::buf_aw-1:0]    rx_adr,
	output logic [spi_pkg::data_w-1:0]    rx_data,
	output logic                          rx_end
);

	logic [2:0] bit_cnt;
	logic [3:0] byte_cnt;
	logic [7:0] shreg;
	logic [7:0] byte_nx;
	logic [spi_pkg::data_w-1:0] acc;
	logic [spi_pkg::data_w-1:0] word_nx;
	logic [spi_pkg::datl_w-1:0] dat_m1;
	logic take;
	logic byte_done;
	logic last_byte;

	assign dat_m1    = dat_len - 5'd1;
	assign take      = rx_active && sample_edge && !rx_end;
	assign byte_done = take && bit_cnt == 3'd7;
	assign last_byte = byte_cnt == dat_m1[3:0];
	// msb first fills from the top
	assign byte_nx   = dat_msb ? {shreg[6:0], miso} : {miso, shreg[7:1]};

	always_comb begin
		word_nx = acc;
		word_nx[{byte_cnt[1:0], 3'b000} +: 8] = byte_nx;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			byte_cnt <= '0;
			rx_end   <= 1'b0;
			rx_we    <= 1'b0;
		end else begin
			rx_we <= byte_done && (byte_cnt[1:0] == 2'd3 || last_byte);
			if (!rx_active) begin
				bit_cnt  <= '0;
				byte_cnt <= '0;
				rx_end   <= 1'b0;
			end else if (take) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					byte_cnt <= byte_cnt + 4'd1;
					rx_end   <= last_byte;
				end
			end
		end
	end

	// unfilled lanes of a short last word go out as zero
	always_ff @(posedge clk) begin
		if (take)
			shreg <= byte_nx;
		if (!rx_active)
			acc <= '0;
		else if (byte_done)
			acc <= (byte_cnt[1:0] == 2'd3) ? '0 : word_nx;
		if (byte_done) begin
			rx_data <= word_nx;
			rx_adr  <= byte_cnt[3:2];
		end
	end

endmodule

// ==== design/io_spi.sv ====
`timescale 1ns/10ps
// spi master on the io bus: registers, buffer, clock, fsm and receiver
module io_spi (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          dma_io_we,
	input  logic [spi_pkg::adr_w-1:0]     dma_io_wadr,
	input  logic [spi_pkg::data_w-1:0]    dma_io_wdata,
	input  logic [spi_pkg::adr_w-1:0]     dma_io_radr,
	input  logic                          dma_io_radr_en,
	input  logic [spi_pkg::data_w-1:0]    dma_io_rdata_in,
	output logic [spi_pkg::data_w-1:0]    dma_io_rdata,
	output logic                          spi_select_io,
	output logic                          spi_sck,
	output logic [1:0]                    spi_csn,
	output logic                          spi_mosi,
	input  logic                          spi_miso
);

	logic bus_we_buf, bus_rd_buf, run, write_mode, cs1;
	logic cpol, cpha, cmd_msb, dat_msb;
	logic [spi_pkg::buf_aw-1:0] bus_buf_adr;
	logic [spi_pkg::div_w-1:0] sck_div;
	logic [spi_pkg::coml_w-1:0] cmd_len;
	logic [spi_pkg::data_w-1:0] cmd_val;
	logic [spi_pkg::datl_w-1:0] dat_len;
	logic [spi_pkg::data_w-1:0] buf_rdata;
	logic [spi_pkg::buf_aw-1:0] word_sel;
	logic int_sck, shift_edge, sample_edge;
	logic sck_en, cs_active, rx_active, run_done;
	logic rx_we, rx_end;
	logic [spi_pkg::buf_aw-1:0] rx_adr;
	logic [spi_pkg::data_w-1:0] rx_data;

	spi_regs i_regs (
		.clk, .rst_n, .dma_io_we, .dma_io_wadr, .dma_io_wdata, .dma_io_radr,
		.dma_io_radr_en, .dma_io_rdata_in, .buf_rdata, .run_done, .dma_io_rdata,
		.bus_we_buf, .bus_rd_buf, .bus_buf_adr, .run, .write_mode, .cs1,
		.select_io(spi_select_io), .cpol, .cpha, .cmd_msb, .dat_msb,
		.sck_div, .cmd_len, .cmd_val, .dat_len
	);

	spi_buffer i_buffer (
		.clk, .bus_we(bus_we_buf), .bus_adr(bus_buf_adr), .bus_wdata(dma_io_wdata),
		.bus_rd(bus_rd_buf), .eng_adr(word_sel), .rx_we, .rx_adr, .rx_data,
		.rdata(buf_rdata)
	);

	spi_clock_gen i_clock_gen (
		.clk, .rst_n, .sck_div, .cpha, .int_sck, .shift_edge, .sample_edge
	);

	spi_sequencer i_sequencer (
		.clk, .rst_n, .run, .write_mode, .cpol, .cpha, .cmd_msb, .dat_msb,
		.cmd_len, .cmd_val, .dat_len, .buf_rdata, .shift_edge, .rx_end,
		.mosi(spi_mosi), .word_sel, .sck_en, .cs_active, .rx_active, .run_done
	);

	spi_miso_rx i_miso_rx (
		.clk, .rst_n, .miso(spi_miso), .sample_edge, .rx_active, .dat_len, .dat_msb,
		.rx_we, .rx_adr, .rx_data, .rx_end
	);

	// idle level is cpol, inverted internal clock when cpol is set
	assign spi_sck = sck_en ? (int_sck ^ cpol) : cpol;
	assign spi_csn = !cs_active ? 2'b11 : (cs1 ? 2'b01 : 2'b10);

endmodule

// ==== testbench/spi_slave_model.sv ====
`timescale 1ns/10ps
// spi device model: records mosi bits and plays back a programmed miso bit stream
module spi_slave_model (
	input  logic         clk,
	input  logic         sck,
	input  logic [1:0]   csn,
	input  logic         mosi,
	input  logic [255:0] miso_stream,
	output logic         miso,
	output logic [255:0] mosi_stream,
	output logic [8:0]   bit_count
);

	logic active;
	logic act_q = 1'b0;
	logic sck_q = 1'b0;
	logic miso_q = 1'b0;
	logic [255:0] rec = '0;
	logic [8:0] bits = '0;
	logic [7:0] pos;

	assign active = csn != 2'b11;
	// each byte travels msb first on the wire
	assign pos = {bits[7:3], ~bits[2:0]};

	assign miso        = miso_q;
	assign mosi_stream = rec;
	assign bit_count   = bits;

	// sck and csn only move on the rising clk edge, so look at them on the falling one
	always @(negedge clk) begin
		act_q <= active;
		sck_q <= sck;
		if (active && !act_q) begin
			bits   <= '0;
			rec    <= '0;
			miso_q <= miso_stream[7];
		end else if (active && sck && !sck_q) begin
			rec[pos] <= mosi;
			bits     <= bits + 9'd1;
		end else if (active && !sck && sck_q) begin
			// next bit goes out on the falling edge
			miso_q <= miso_stream[pos];
		end
	end

endmodule

// ==== testbench/tb_io_spi.sv ====
`timescale 1ns/10ps
// testbench for the io bus spi master against a serial device model
module tb_io_spi;

	localparam int max_div = 3;
	// slowest transfer with four bytes of margin
	localparam int xfer_cycles = (4 + 16 + 4) * 8 * 2 * (max_div + 1);
	localparam int limit_ns    = 2 * (6 * 200 + 4 * xfer_cycles) * 100;

	logic clk;
	logic rst_n;
	logic dma_io_we;
	logic [spi_pkg::adr_w-1:0] dma_io_wadr;
	logic [spi_pkg::data_w-1:0] dma_io_wdata;
	logic [spi_pkg::adr_w-1:0] dma_io_radr;
	logic dma_io_radr_en;
	logic [spi_pkg::data_w-1:0] dma_io_rdata_in;
	logic [spi_pkg::data_w-1:0] dma_io_rdata;
	logic spi_select_io, spi_sck, spi_mosi, spi_miso;
	logic [1:0] spi_csn;
	logic [255:0] miso_stream, mosi_stream, mode0_stream;
	logic [8:0] bit_count;

	string test_name;
	int errs, n_pass, n_fail;
	int cfg_cl, cfg_dl, cfg_div;
	bit cfg_cs1, cfg_cmd_msb, cfg_dat_msb;
	logic [31:0] cfg_cmd;
	logic [31:0] cfg_words [4];
	logic [7:0] cfg_rx [16];

	io_spi i_dut (
		.clk, .rst_n, .dma_io_we, .dma_io_wadr, .dma_io_wdata, .dma_io_radr,
		.dma_io_radr_en, .dma_io_rdata_in, .dma_io_rdata, .spi_select_io,
		.spi_sck, .spi_csn, .spi_mosi, .spi_miso
	);

	spi_slave_model i_slave (
		.clk, .sck(spi_sck), .csn(spi_csn), .mosi(spi_mosi), .miso_stream,
		.miso(spi_miso), .mosi_stream, .bit_count
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [7:0] reverse_bits(input logic [7:0] b);
		for (int i = 0; i < 8; i++)
			reverse_bits[i] = b[7-i];
	endfunction

	// byte as it appears msb first on the wire
	function automatic logic [7:0] wire_byte(input logic [7:0] b, input bit msb);
		return msb ? b : reverse_bits(b);
	endfunction

	function automatic logic [31:0] mode_word(input bit mode3);
		logic [31:0] m;
		m = 32'd1 << spi_pkg::mode_select_io;
		m |= 32'(cfg_cmd_msb) << spi_pkg::mode_cmd_msb;
		m |= 32'(cfg_dat_msb) << spi_pkg::mode_dat_msb;
		if (mode3)
			m |= (32'd1 << spi_pkg::mode_cpha) | (32'd1 << spi_pkg::mode_cpol);
		return m;
	endfunction

	task automatic check_word(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
			errs++;
		end
	endtask

	task automatic finish_test();
		if (errs == 0) begin
			n_pass++;
			$display("%s: ok", test_name);
		end else begin
			n_fail++;
			$display("%s: %0d errors", test_name, errs);
		end
	endtask

	task automatic bus_write(input logic [13:0] adr, input logic [31:0] data);
		@(negedge clk);
		dma_io_we    = 1'b1;
		dma_io_wadr  = adr;
		dma_io_wdata = data;
		@(negedge clk);
		dma_io_we = 1'b0;
	endtask

	// data comes back in the cycle after the strobe
	task automatic bus_read(input logic [13:0] adr, output logic [31:0] data);
		@(negedge clk);
		dma_io_radr_en = 1'b1;
		dma_io_radr    = adr;
		@(negedge clk);
		dma_io_radr_en = 1'b0;
		data = dma_io_rdata;
	endtask

	task automatic wait_idle();
		logic [31:0] v;
		logic [1:0] exp_csn;
		bit seen;
		exp_csn = cfg_cs1 ? 2'b01 : 2'b10;
		seen = 1'b0;
		v = 32'd1;
		while (v[spi_pkg::exec_run]) begin
			bus_read(spi_pkg::adr_exec, v);
			if (spi_csn != 2'b11) begin
				seen = 1'b1;
				check_word("active csn", 32'(exp_csn), 32'(spi_csn));
			end
		end
		assert (seen) else begin
			$display("%s: chip select never went active", test_name);
			errs++;
		end
		check_word("csn after run", 32'h3, 32'(spi_csn));
	endtask

	task automatic pick_config();
		cfg_cl      = $urandom_range(4, 1);
		cfg_dl      = $urandom_range(16, 1);
		cfg_div     = $urandom_range(max_div, 0);
		cfg_cmd     = $urandom;
		cfg_cs1     = 1'($urandom);
		cfg_cmd_msb = 1'($urandom);
		cfg_dat_msb = 1'($urandom);
		for (int w = 0; w < 4; w++)
			cfg_words[w] = $urandom;
		for (int i = 0; i < 16; i++)
			cfg_rx[i] = 8'($urandom);
	endtask

	task automatic start_xfer(input bit mode3, input bit write);
		bus_write(spi_pkg::adr_mode, mode_word(mode3));
		bus_write(spi_pkg::adr_sdiv, 32'(cfg_div));
		bus_write(spi_pkg::adr_coml, 32'(cfg_cl));
		bus_write(spi_pkg::adr_comv, cfg_cmd);
		bus_write(spi_pkg::adr_datl, 32'(cfg_dl));
		for (int w = 0; w < 4; w++)
			bus_write({spi_pkg::adr_datx, 2'(w)}, cfg_words[w]);
		// dummy bytes on miso while the command goes out
		miso_stream = '0;
		if (!write) begin
			for (int i = 0; i < cfg_dl; i++)
				miso_stream[8*(cfg_cl+i) +: 8] = cfg_rx[i];
		end
		check_word("idle sck", 32'(mode3), 32'(spi_sck));
		bus_write(spi_pkg::adr_exec, (32'(cfg_cs1) << spi_pkg::exec_cs1) |
			(32'(write) << spi_pkg::exec_write) | 32'd1);
		wait_idle();
		check_word("sck after run", 32'(mode3), 32'(spi_sck));
	endtask

	task automatic check_mosi(input bit write);
		logic [7:0] b;
		bit msb;
		int j;
		check_word("bit count", 32'(8 * (cfg_cl + cfg_dl)), 32'(bit_count));
		for (int i = 0; i < cfg_cl + cfg_dl; i++) begin
			j = i - cfg_cl;
			if (i < cfg_cl) begin
				b   = cfg_cmd[8*i +: 8];
				msb = cfg_cmd_msb;
			end else begin
				b   = write ? cfg_words[j/4][8*(j%4) +: 8] : 8'h00;
				msb = cfg_dat_msb;
			end
			check_word($sformatf("mosi byte %0d", i), 32'(wire_byte(b, msb)),
				32'(mosi_stream[8*i +: 8]));
		end
	endtask

	task automatic reset_test();
		logic [31:0] v;
		test_name = "reset_values";
		errs = 0;
		check_word("csn", 32'h3, 32'(spi_csn));
		check_word("sck", 32'h0, 32'(spi_sck));
		check_word("mosi", 32'h0, 32'(spi_mosi));
		check_word("select_io", 32'h1, 32'(spi_select_io));
		bus_read(spi_pkg::adr_mode, v);
		check_word("mode", 32'd1 << spi_pkg::mode_select_io, v);
		bus_read(spi_pkg::adr_coml, v);
		check_word("coml", 32'd1, v);
		bus_read(spi_pkg::adr_exec, v);
		check_word("exec", 32'd0, v);
		// no spi register here so other devices answer
		bus_read(14'h0123, v);
		check_word("pass-through", dma_io_rdata_in, v);
		finish_test();
	endtask

	task automatic readback_test();
		logic [31:0] r, v, mask;
		logic [31:0] words [4];
		test_name = "register_readback";
		errs = 0;
		mask = (32'd1 << spi_pkg::mode_select_io) | (32'd1 << spi_pkg::mode_cpha) |
			(32'd1 << spi_pkg::mode_cpol) | (32'd1 << spi_pkg::mode_cmd_msb) |
			(32'd1 << spi_pkg::mode_dat_msb);
		r = $urandom;
		// select_io leaves its reset value here
		r[spi_pkg::mode_select_io] = 1'b0;
		bus_write(spi_pkg::adr_mode, r);
		bus_read(spi_pkg::adr_mode, v);
		check_word("mode", r & mask, v);
		check_word("select_io", 32'h0, 32'(spi_select_io));
		r = $urandom;
		bus_write(spi_pkg::adr_sdiv, r);
		bus_read(spi_pkg::adr_sdiv, v);
		check_word("sdiv", r & ((32'd1 << spi_pkg::div_w) - 32'd1), v);
		r = $urandom;
		bus_write(spi_pkg::adr_comv, r);
		bus_read(spi_pkg::adr_comv, v);
		check_word("comv", r, v);
		r = $urandom;
		bus_write(spi_pkg::adr_datl, r);
		bus_read(spi_pkg::adr_datl, v);
		check_word("datl", r & ((32'd1 << spi_pkg::datl_w) - 32'd1), v);
		for (int w = 0; w < 4; w++) begin
			words[w] = $urandom;
			bus_write({spi_pkg::adr_datx, 2'(w)}, words[w]);
		end
		for (int w = 0; w < 4; w++) begin
			bus_read({spi_pkg::adr_datx, 2'(w)}, v);
			check_word($sformatf("buffer word %0d", w), words[w], v);
		end
		finish_test();
	endtask

	task automatic write_test(input bit mode3);
		test_name = mode3 ? "write_mode3" : "write_mode0";
		errs = 0;
		start_xfer(mode3, 1'b1);
		check_mosi(1'b1);
		check_word("select_io", 32'h1, 32'(spi_select_io));
		if (!mode3) begin
			mode0_stream = mosi_stream;
		end else begin
			assert (mosi_stream === mode0_stream) else begin
				$display("%s: recorded bytes differ from mode 0", test_name);
				errs++;
			end
		end
		finish_test();
	endtask

	task automatic read_test(input bit mode3);
		logic [31:0] v, exp;
		int j;
		test_name = mode3 ? "read_mode3" : "read_mode0";
		errs = 0;
		start_xfer(mode3, 1'b0);
		check_mosi(1'b0);
		for (int w = 0; w < 4; w++) begin
			exp = cfg_words[w];
			// lanes past the last byte of a touched word come back as zero
			if (4 * w < cfg_dl) begin
				for (int k = 0; k < 4; k++) begin
					j = 4 * w + k;
					if (j < cfg_dl)
						exp[8*k +: 8] = wire_byte(cfg_rx[j], cfg_dat_msb);
					else
						exp[8*k +: 8] = 8'h00;
				end
			end
			bus_read({spi_pkg::adr_datx, 2'(w)}, v);
			check_word($sformatf("buffer word %0d", w), exp, v);
		end
		finish_test();
	endtask

	initial begin
		#(limit_ns);
		$display("timeout: tests did not finish within %0d ns", limit_ns);
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h1de07c74));
		rst_n           = 1'b0;
		dma_io_we       = 1'b0;
		dma_io_wadr     = '0;
		dma_io_wdata    = '0;
		dma_io_radr     = '0;
		dma_io_radr_en  = 1'b0;
		dma_io_rdata_in = $urandom;
		miso_stream     = '0;
		mode0_stream    = '0;
		n_pass = 0;
		n_fail = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		reset_test();
		readback_test();
		pick_config();
		write_test(1'b0);
		read_test(1'b0);
		write_test(1'b1);
		read_test(1'b1);
		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== build.f ====
design/spi_pkg.sv
design/spi_regs.sv
design/spi_buffer.sv
design/spi_clock_gen.sv
design/spi_sequencer.sv
design/spi_miso_rx.sv
design/io_spi.sv
testbench/spi_slave_model.sv
testbench/tb_io_spi.sv

// ==== Makefile ====
# verilator build and run for the io bus spi master testbench

VERILATOR ?= verilator
TOP       ?= tb_io_spi
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
